// ==== video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Bits per colour component
`define VID_DEPTH 4

// Output line layout in clocks
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3

// Output frame layout in lines
`define V_ACTIVE 8
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 2

// Entries per line buffer bank, also the widest input line
`define LINE_DEPTH 64

// Counter and measurement width
`define CNT_W 12

`endif

// ==== video_pkg.sv ====
`default_nettype none
`include "video_consts.svh"

package video_pkg;

	typedef struct packed {
		logic [`VID_DEPTH-1:0] red;
		logic [`VID_DEPTH-1:0] green;
		logic [`VID_DEPTH-1:0] blue;
	} rgb_t;

	// Game side video, syncs active low
	typedef struct packed {
		rgb_t rgb;
		logic pix_en;
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
	} src_video_t;

	// Raw output timing straight from the counters
	typedef struct packed {
		logic             hsync_n;
		logic             vsync_n;
		logic [`CNT_W-1:0] h_pos;
		logic [`CNT_W-1:0] v_pos;
	} out_timing_t;

	typedef struct packed {
		rgb_t rgb;
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
	} out_video_t;

	typedef struct packed {
		logic             locked;
		logic [`CNT_W-1:0] width;
		logic [`CNT_W-1:0] height;
	} format_t;

endpackage

`default_nettype wire

// ==== vga_sync_pulses.sv ====
`default_nettype none
`include "video_consts.svh"

module vga_sync_pulses import video_pkg::*; (
	input  wire         i_clk,
	input  wire         i_rst,
	output out_timing_t o_timing
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

	// Sync windows sit right after the front porch
	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;

	logic [`CNT_W-1:0] h_cnt;
	logic [`CNT_W-1:0] v_cnt;
	logic              line_end;
	logic              frame_end;

	assign line_end = (h_cnt == `CNT_W'(H_TOTAL - 1));
	assign frame_end = (v_cnt == `CNT_W'(V_TOTAL - 1));

	//////////////////////////////////////////////////
	// Position counters
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			// Vertical steps once per wrap
			if (frame_end) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Sync decode, both low inside their windows
	always_comb begin
		o_timing.h_pos = h_cnt;
		o_timing.v_pos = v_cnt;
		o_timing.hsync_n = !((h_cnt >= `CNT_W'(H_SYNC_START)) &&
			(h_cnt < `CNT_W'(H_SYNC_END)));
		o_timing.vsync_n = !((v_cnt >= `CNT_W'(V_SYNC_START)) &&
			(v_cnt < `CNT_W'(V_SYNC_END)));
	end

endmodule

`default_nettype wire

// ==== sync_to_blanking.sv ====
`default_nettype none
`include "video_consts.svh"

module sync_to_blanking import video_pkg::*; (
	input  wire               i_clk,
	input  wire               i_rst,
	input  wire out_timing_t  i_timing,
	output out_video_t        o_video,
	output logic [`CNT_W-1:0] o_h_pos,
	output logic [`CNT_W-1:0] o_v_pos
);

	typedef enum logic [1:0] {
		SYNC,
		BACK_PORCH,
		ACTIVE,
		FRONT_PORCH
	} phase_t;

	typedef struct packed {
		phase_t            phase;
		logic [`CNT_W-1:0] cnt;
	} track_t;

	// One step of a phase tracker, shared by both axes
	function automatic track_t step(track_t cur, logic fall, int sync_len, int back_len,
			int active_len);
		track_t nxt;
		nxt.phase = cur.phase;
		nxt.cnt = cur.cnt + 1'b1;
		if (fall) begin
			// Sync edge always restarts the cycle
			nxt.phase = SYNC;
			nxt.cnt = '0;
		end else begin
			case (cur.phase)
				SYNC: begin
					if (cur.cnt == `CNT_W'(sync_len - 1)) begin
						nxt.phase = BACK_PORCH;
						nxt.cnt = '0;
					end
				end
				BACK_PORCH: begin
					if (cur.cnt == `CNT_W'(back_len - 1)) begin
						nxt.phase = ACTIVE;
						nxt.cnt = '0;
					end
				end
				ACTIVE: begin
					if (cur.cnt == `CNT_W'(active_len - 1)) begin
						nxt.phase = FRONT_PORCH;
						nxt.cnt = '0;
					end
				end
				default: begin
					// Front porch just waits for the next sync
					nxt.cnt = '0;
				end
			endcase
		end
		return nxt;
	endfunction

	track_t h_trk;
	track_t v_trk;
	track_t h_next;
	track_t v_next;
	logic   hsync_q;
	logic   vsync_q;
	logic   h_fall;
	logic   v_fall;
	logic   line_start;

	assign h_fall = hsync_q && !i_timing.hsync_n;
	assign v_fall = vsync_q && !i_timing.vsync_n;

	//////////////////////////////////////////////////
	// Phase trackers
	//////////////////////////////////////////////////

	always_comb begin
		h_next = step(h_trk, h_fall, `H_SYNC, `H_BACK, `H_ACTIVE);
		// A line begins where the back porch hands over to active video
		line_start = (h_trk.phase == BACK_PORCH) && (h_next.phase == ACTIVE);
		if (v_fall || line_start) begin
			v_next = step(v_trk, v_fall, `V_SYNC, `V_BACK, `V_ACTIVE);
		end else begin
			v_next = v_trk;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			h_trk <= '{phase: FRONT_PORCH, cnt: '0};
			v_trk <= '{phase: FRONT_PORCH, cnt: '0};
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			h_trk <= h_next;
			v_trk <= v_next;
			hsync_q <= i_timing.hsync_n;
			vsync_q <= i_timing.vsync_n;
		end
	end

	// Position delayed to match the syncs
	always_ff @(posedge i_clk) begin
		o_h_pos <= i_timing.h_pos;
		o_v_pos <= i_timing.v_pos;
	end

	always_comb begin
		o_video.rgb = '0;
		o_video.hsync_n = hsync_q;
		o_video.vsync_n = vsync_q;
		o_video.hblank = (h_trk.phase != ACTIVE);
		o_video.vblank = (v_trk.phase != ACTIVE);
	end

endmodule

`default_nettype wire

// ==== format_meter.sv ====
`default_nettype none
`include "video_consts.svh"

module format_meter import video_pkg::*; (
	input  wire             i_clk,
	input  wire             i_rst,
	input  wire src_video_t i_src,
	output format_t         o_format
);

	logic [`CNT_W-1:0] pix_cnt;
	logic [`CNT_W-1:0] line_width;
	logic [`CNT_W-1:0] line_cnt;
	logic              hblank_q;
	logic              vsync_q;
	logic              pix_valid;
	logic              line_done;
	logic              frame_start;
	logic              same_format;

	assign pix_valid = i_src.pix_en && !i_src.hblank && !i_src.vblank;
	assign line_done = !hblank_q && i_src.hblank;
	assign frame_start = vsync_q && !i_src.vsync_n;

	// Compared against the format reported for the last frame
	assign same_format = (line_width == o_format.width) &&
		(line_cnt == o_format.height) && (line_width != '0);

	//////////////////////////////////////////////////
	// Line and frame measurement
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pix_cnt <= '0;
			line_width <= '0;
			line_cnt <= '0;
			hblank_q <= 1'b1;
			vsync_q <= 1'b1;
			o_format <= '0;
		end else begin
			hblank_q <= i_src.hblank;
			vsync_q <= i_src.vsync_n;

			if (line_done) begin
				pix_cnt <= '0;
				// Lines without pixels are blank lines
				if (pix_cnt != '0) begin
					line_width <= pix_cnt;
					line_cnt <= line_cnt + 1'b1;
				end
			end else if (pix_valid) begin
				pix_cnt <= pix_cnt + 1'b1;
			end

			if (frame_start) begin
				o_format.width <= line_width;
				o_format.height <= line_cnt;
				o_format.locked <= same_format;
				line_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== scan_line_buffer.sv ====
`default_nettype none
`include "video_consts.svh"

module scan_line_buffer import video_pkg::*; (
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire src_video_t        i_src,
	input  wire out_video_t        i_video,
	input  wire [`CNT_W-1:0]       i_h_pos,
	output out_video_t             o_vga
);

	localparam int AW = $clog2(`LINE_DEPTH);

	// Bank select is the top address bit
	rgb_t mem [0:2*`LINE_DEPTH-1];

	logic [AW-1:0] wr_addr;
	logic [AW-1:0] wr_slot;
	logic          wr_bank;
	logic          wr_en;
	logic          src_hblank_q;
	logic          line_begin;
	logic          line_done;
	rgb_t          rd_data;
	out_video_t    video_q;

	assign line_begin = src_hblank_q && !i_src.hblank;
	assign line_done = !src_hblank_q && i_src.hblank;
	assign wr_en = i_src.pix_en && !i_src.hblank;
	assign wr_slot = line_begin ? '0 : wr_addr;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_addr <= '0;
			wr_bank <= 1'b0;
			src_hblank_q <= 1'b1;
		end else begin
			src_hblank_q <= i_src.hblank;
			// Finished line becomes the read bank
			if (line_done) begin
				wr_bank <= ~wr_bank;
			end
			if (wr_en) begin
				wr_addr <= wr_slot + 1'b1;
			end else if (line_begin) begin
				wr_addr <= '0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			mem[{wr_bank, wr_slot}] <= i_src.rgb;
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_video.hblank && !i_video.vblank) begin
			rd_data <= mem[{~wr_bank, i_h_pos[AW-1:0]}];
		end
	end

	// Timing waits one clock for the read data
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			video_q <= '{rgb: '0, hsync_n: 1'b1, vsync_n: 1'b1, hblank: 1'b1, vblank: 1'b1};
		end else begin
			video_q <= i_video;
		end
	end

	always_comb begin
		o_vga = video_q;
		if (video_q.hblank || video_q.vblank) begin
			o_vga.rgb = '0;
		end else begin
			o_vga.rgb = rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== video_out_top.sv ====
`default_nettype none
`include "video_consts.svh"

module video_out_top import video_pkg::*; (
	input  wire             i_clk,
	input  wire             i_rst,
	input  wire src_video_t i_src,
	output out_video_t      o_vga,
	output format_t         o_format
);

	out_timing_t       timing;
	out_video_t        blank_video;
	logic [`CNT_W-1:0] blank_h_pos;

	// Output timing
	vga_sync_pulses u_sync (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.o_timing (timing)
	);

	sync_to_blanking u_blank (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_timing (timing),
		.o_video  (blank_video),
		.o_h_pos  (blank_h_pos),
		.o_v_pos  ()
	);

	// Input side measurement
	format_meter u_meter (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_src    (i_src),
		.o_format (o_format)
	);

	scan_line_buffer u_buffer (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_src   (i_src),
		.i_video (blank_video),
		.i_h_pos (blank_h_pos),
		.o_vga   (o_vga)
	);

endmodule

`default_nettype wire

// ==== tb_video_out.sv ====
`default_nettype none
`include "video_consts.svh"

module tb_video_out import video_pkg::*; ();

	localparam int LINE_CLKS = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int FRAME_LINES = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int SRC_LINE = 48;
	localparam int TIMEOUT = 1000;

	logic       clk;
	logic       i_rst;
	src_video_t src;
	out_video_t vga;
	format_t    fmt;
	integer     seed = 32'h9214e53a;
	int         err_cnt = 0;
	int         check_cnt = 0;
	int         test_cnt = 0;

	video_out_top u_dut (
		.i_clk    (clk),
		.i_rst    (i_rst),
		.i_src    (src),
		.o_vga    (vga),
		.o_format (fmt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Drive and sample point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic timeout_error(input string what);
		$display("Timeout after %0d clocks waiting for %s", TIMEOUT, what);
		err_cnt++;
	endtask

	task automatic report_test(input string name, input int start_err);
		test_cnt++;
		$display("test %s: %s, %0d errors", name,
			(err_cnt == start_err) ? "ok" : "bad", err_cnt - start_err);
	endtask

	// Selects one of the o_vga timing bits
	function automatic logic get_bit(input int sel);
		case (sel)
			0: return vga.hsync_n;
			1: return vga.vsync_n;
			2: return vga.hblank;
			default: return vga.vblank;
		endcase
	endfunction

	function automatic string bit_name(input int sel);
		case (sel)
			0: return "o_vga.hsync_n";
			1: return "o_vga.vsync_n";
			2: return "o_vga.hblank";
			default: return "o_vga.vblank";
		endcase
	endfunction

	// Red carries the x index, blue the tint
	function automatic rgb_t pixel(input int x, input logic [3:0] tint);
		rgb_t p;
		p.red = 4'(x);
		p.green = '0;
		p.blue = tint;
		return p;
	endfunction

	task automatic wait_edge(input int sel, input logic level);
		logic prev;
		int   n;
		prev = get_bit(sel);
		for (n = 0; n < TIMEOUT; n++) begin
			next_cycle();
			if (prev !== level && get_bit(sel) === level) begin
				break;
			end
			prev = get_bit(sel);
		end
		if (n == TIMEOUT) begin
			timeout_error({bit_name(sel), " edge"});
		end
	endtask

	// Counts clocks at level, starting at the current sample
	task automatic run_length(input int sel, input logic level, output int len);
		int n;
		len = 1;
		for (n = 0; n < TIMEOUT; n++) begin
			next_cycle();
			if (get_bit(sel) !== level) begin
				break;
			end
			len++;
		end
		if (n == TIMEOUT) begin
			timeout_error({bit_name(sel), " to change level"});
		end
	endtask

	task automatic wait_active_line();
		logic prev;
		int   n;
		prev = vga.hblank;
		for (n = 0; n < TIMEOUT; n++) begin
			next_cycle();
			if (prev === 1'b1 && vga.hblank === 1'b0 && vga.vblank === 1'b0) begin
				break;
			end
			prev = vga.hblank;
		end
		if (n == TIMEOUT) begin
			timeout_error("an active output line");
		end
	endtask

	//////////////////////////////////////////////////
	// Source pattern generator
	//////////////////////////////////////////////////

	// One 48 clock input line, pix_en on even clocks
	task automatic send_line(input int width, input logic [3:0] tint, input logic vb,
			input logic vs_n);
		int c;
		for (c = 0; c < SRC_LINE; c++) begin
			next_cycle();
			src.hblank = (c >= 2 * width);
			src.vblank = vb;
			src.pix_en = (c % 2 == 0);
			src.rgb = (c < 2 * width && !vb) ? pixel(c / 2, tint) : '0;
			src.hsync_n = !(c >= 2 * width + 2 && c < 2 * width + 6);
			src.vsync_n = vs_n;
		end
	endtask

	// Vsync line, one more blank line, then the active lines
	task automatic send_frame(input int width, input int height, input logic [3:0] tint);
		int l;
		send_line(width, tint, 1'b1, 1'b0);
		send_line(width, tint, 1'b1, 1'b1);
		for (l = 0; l < height; l++) begin
			send_line(width, tint, 1'b0, 1'b1);
		end
	endtask

	task automatic check_format(input logic locked, input int width, input int height);
		compare("o_format.locked", fmt.locked, locked);
		compare("o_format.width", fmt.width, width);
		compare("o_format.height", fmt.height, height);
	endtask

	task automatic check_idle_outputs();
		compare("o_vga.hsync_n", vga.hsync_n, 1);
		compare("o_vga.vsync_n", vga.vsync_n, 1);
		compare("o_vga.hblank", vga.hblank, 1);
		compare("o_vga.vblank", vga.vblank, 1);
		compare("o_vga.rgb", vga.rgb, 0);
		compare("o_format.locked", fmt.locked, 0);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int start_err;
		int n;
		start_err = err_cnt;
		for (n = 0; n < 8; n++) begin
			next_cycle();
			if (n >= 2) begin
				check_idle_outputs();
			end
		end
		i_rst = 1'b0;
		next_cycle();
		check_idle_outputs();
		report_test("reset", start_err);
	endtask

	task automatic test_timing();
		int start_err;
		int low;
		int high;
		int len;
		start_err = err_cnt;
		wait_edge(0, 1'b0);
		run_length(0, 1'b0, low);
		run_length(0, 1'b1, high);
		compare("o_vga.hsync_n low clocks", low, `H_SYNC);
		compare("o_vga.hsync_n period", low + high, LINE_CLKS);
		wait_edge(2, 1'b1);
		run_length(2, 1'b1, len);
		compare("o_vga.hblank high clocks", len, `H_FRONT + `H_SYNC + `H_BACK);
		wait_edge(1, 1'b0);
		run_length(1, 1'b0, low);
		run_length(1, 1'b1, high);
		compare("o_vga.vsync_n low clocks", low, `V_SYNC * LINE_CLKS);
		compare("o_vga.vsync_n period", low + high, FRAME_LINES * LINE_CLKS);
		wait_edge(3, 1'b1);
		run_length(3, 1'b1, len);
		compare("o_vga.vblank high clocks", len, (`V_FRONT + `V_SYNC + `V_BACK) * LINE_CLKS);
		report_test("timing", start_err);
	endtask

	task automatic test_alignment();
		int start_err;
		int n;
		start_err = err_cnt;
		wait_edge(2, 1'b1);
		for (n = 0; n < TIMEOUT; n++) begin
			if (vga.hsync_n === 1'b0) begin
				break;
			end
			next_cycle();
		end
		if (n == TIMEOUT) begin
			timeout_error("o_vga.hsync_n to fall after hblank");
		end
		compare("o_vga.hsync_n fall after hblank rise", n, `H_FRONT);
		// A full frame of blanked pixels
		for (n = 0; n < FRAME_LINES * LINE_CLKS; n++) begin
			next_cycle();
			if (vga.hblank !== 1'b0 || vga.vblank !== 1'b0) begin
				compare("o_vga.rgb", vga.rgb, 0);
			end
		end
		report_test("alignment", start_err);
	endtask

	task automatic test_format();
		int start_err;
		start_err = err_cnt;
		repeat (3) send_frame(16, 6, 4'h3);
		check_format(1'b1, 16, 6);
		// Report lags one frame behind the input
		repeat (2) send_frame(12, 6, 4'h3);
		check_format(1'b0, 12, 6);
		send_frame(12, 6, 4'h3);
		check_format(1'b1, 12, 6);
		report_test("format", start_err);
	endtask

	task automatic check_replay(input logic [3:0] tint);
		int x;
		send_line(16, tint, 1'b0, 1'b1);
		wait_edge(2, 1'b1);
		wait_active_line();
		for (x = 0; x < 16; x++) begin
			if (vga.hblank !== 1'b0) begin
				break;
			end
			compare("o_vga.rgb", vga.rgb, pixel(x, tint));
			next_cycle();
		end
		compare("active pixels per line", x, `H_ACTIVE);
	endtask

	task automatic test_replay();
		int         start_err;
		int         k;
		logic [3:0] tint;
		start_err = err_cnt;
		for (k = 0; k < 3; k++) begin
			if (k == 0) begin
				tint = 4'h9;
			end else begin
				tint = 4'($random(seed));
			end
			check_replay(tint);
		end
		report_test("replay", start_err);
	endtask

	initial begin
		i_rst = 1'b1;
		src = '{rgb: '0, pix_en: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1, hblank: 1'b1, vblank: 1'b1};
		test_reset();
		test_timing();
		test_alignment();
		test_format();
		test_replay();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
video_pkg.sv
vga_sync_pulses.sv
sync_to_blanking.sv
format_meter.sv
scan_line_buffer.sv
video_out_top.sv
tb_video_out.sv
